// ==== list.f ====
rtl/ram_geom_pkg.sv
rtl/chan_pkg.sv
rtl/ram_wr_if.sv
rtl/srfram_core.sv
rtl/rd_channel.sv
rtl/wr_channel.sv
rtl/srfram_channelized.sv
tb/tb_srfram_channelized.sv

// ==== tb/tb_srfram_channelized.sv ====
/*
 * Self-checking testbench for the channelized RAM.
 *   reference memory model and expected read-data queue
 *   immediate assertions on data, latency, hold and back-pressure
 *   directed and random valid/ready traffic, cycle-count timeout
 */

`timescale 1ns/1ps

module tb_srfram_channelized;

   localparam int MAX_CYCLES  = 4000;         // About four times the test length.
   localparam int DRAIN_LIMIT = 200;          // Cycles left for responses after requests.

   logic                              rclk;
   logic                              rst_rclk_n;
   logic                              ar_valid;
   logic                              ar_ready;
   logic [ram_geom_pkg::ADDR_W-1:0]   ar_addr;
   logic                              r_valid;
   logic                              r_ready;
   logic [ram_geom_pkg::WIDTH-1:0]    r_data;
   logic                              aw_valid;
   logic                              aw_ready;
   logic [ram_geom_pkg::ADDR_W-1:0]   aw_addr;
   logic [ram_geom_pkg::WIDTH-1:0]    aw_data;
   logic [ram_geom_pkg::WIDTH-1:0]    aw_bwe;
   logic                              b_valid;
   logic                              b_ready;

   // ==============================
   // Reference model state
   // ==============================

   logic [ram_geom_pkg::WIDTH-1:0]    model [ram_geom_pkg::DEPTH];
   logic [ram_geom_pkg::WIDTH-1:0]    exp_q [$];      // Expected r_data in order.
   logic [ram_geom_pkg::ADDR_W-1:0]   aw_addr_q [$];  // Writes awaiting b.
   int                                ar_edge_q [$];  // Edge of each ar transfer.
   int                                wr_pend [ram_geom_pkg::DEPTH];
   int                                value_errors = 0;
   int                                proto_errors = 0;
   int                                aw_count = 0;
   int                                b_count = 0;
   int                                cycles = 0;
   int                                edge_n = 0;
   int                                r_low_edge = 0;
   int unsigned                       seed;
   logic                              ar_hs = 1'b0;
   logic                              aw_hs = 1'b0;
   logic                              lat1 = 1'b0;
   logic                              lat2 = 1'b0;
   logic                              r_hold = 1'b0;
   logic                              b_hold = 1'b0;
   logic                              rst_low_prev = 1'b0;
   logic [ram_geom_pkg::WIDTH-1:0]    r_data_prev;

   srfram_channelized srfram_channelized_i (
      .rclk       (rclk),
      .rst_rclk_n (rst_rclk_n),
      .ar_valid   (ar_valid),
      .ar_ready   (ar_ready),
      .ar_addr    (ar_addr),
      .r_valid    (r_valid),
      .r_ready    (r_ready),
      .r_data     (r_data),
      .aw_valid   (aw_valid),
      .aw_ready   (aw_ready),
      .aw_addr    (aw_addr),
      .aw_data    (aw_data),
      .aw_bwe     (aw_bwe),
      .b_valid    (b_valid),
      .b_ready    (b_ready)
   );

   initial begin
      rclk = 1'b0;
      forever #4 rclk = ~rclk;               // 8 ns period.
   end

   task automatic report_value_error(input string msg);
      value_errors++;
      $display("Fail at %0t ns: %s", $time, msg);
   endtask

   task automatic report_protocol_error(input string msg);
      proto_errors++;
      $display("Protocol error at %0t ns: %s", $time, msg);
   endtask

   task automatic close_run(input bit timed_out);
      $display("Errors: value %0d, protocol %0d; aw transfers %0d, b transfers %0d",
               value_errors, proto_errors, aw_count, b_count);
      if (value_errors == 0 && proto_errors == 0 && !timed_out) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   endtask

   // ==============================
   // Checks at each rising edge
   // ==============================

   always @(posedge rclk) begin : monitor
      logic [ram_geom_pkg::WIDTH-1:0]  exp_word;
      logic [ram_geom_pkg::ADDR_W-1:0] done_addr;
      int                              ar_edge;
      ar_hs = ar_valid && ar_ready;
      aw_hs = aw_valid && aw_ready;
      if (!rst_rclk_n || rst_low_prev) begin
         assert (!r_valid && !b_valid)
            else report_protocol_error("r_valid or b_valid is high around reset.");
         assert (ar_valid || !ar_ready)
            else report_protocol_error("ar_ready is high without ar_valid after reset.");
         assert (aw_valid || !aw_ready)
            else report_protocol_error("aw_ready is high without aw_valid after reset.");
      end
      rst_low_prev = !rst_rclk_n;
      if (rst_rclk_n) begin
         edge_n++;
         if (!r_ready) r_low_edge = edge_n;
         // First read into an empty pipeline.
         if (lat2) assert (r_valid)
            else report_protocol_error("r_valid did not rise one cycle after the ar transfer.");
         if (lat1) assert (!r_valid)
            else report_protocol_error("r_valid rose at the ar transfer edge itself.");
         lat2 = lat1;
         lat1 = ar_hs && exp_q.size() == 0;
         if (r_hold) begin
            assert (r_valid) else report_protocol_error("r_valid dropped before its transfer.");
            assert (r_data === r_data_prev)
               else report_value_error($sformatf("r_data moved from %h to %h while held",
                                                 r_data_prev, r_data));
         end
         if (b_hold) assert (b_valid)
            else report_protocol_error("b_valid dropped before its transfer.");
         r_hold      = r_valid && !r_ready;
         b_hold      = b_valid && !b_ready;
         r_data_prev = r_data;
         assert (!(ar_valid && r_ready) || ar_ready)
            else report_protocol_error("ar_ready is low although r_ready is high.");
         assert (!(aw_valid && b_ready) || aw_ready)
            else report_protocol_error("aw_ready is low although b_ready is high.");
         assert (!(exp_q.size() == 2 && !r_ready) || !ar_ready)
            else report_protocol_error("ar_ready is high with two reads unconsumed.");
         assert (!(aw_count - b_count == 2 && !b_ready) || !aw_ready)
            else report_protocol_error("aw_ready is high with two writes unacknowledged.");
         if (r_valid && r_ready) begin
            assert (exp_q.size() > 0)
               else report_protocol_error("A read response came with no read in flight.");
            if (exp_q.size() > 0) begin
               exp_word = exp_q.pop_front();
               assert (r_data === exp_word)
                  else report_value_error($sformatf("r_data %h, expected %h",
                                                    r_data, exp_word));
            end
            if (ar_edge_q.size() > 0) begin
               ar_edge = ar_edge_q.pop_front();
               // r_ready stayed high since the request, so no stall allowed.
               if (r_low_edge <= ar_edge) assert (edge_n == ar_edge + 2)
                  else report_protocol_error("A read came back with the wrong latency.");
            end
         end
         if (b_valid && b_ready) begin
            assert (aw_addr_q.size() > 0)
               else report_protocol_error("A write response came with no write in flight.");
            if (aw_addr_q.size() > 0) begin
               done_addr = aw_addr_q.pop_front();
               wr_pend[done_addr]--;
            end
            b_count++;
         end
         if (aw_hs) begin
            for (int i = 0; i < ram_geom_pkg::WIDTH; i++) begin
               if (aw_bwe[i]) model[aw_addr][i] = aw_data[i];   // Only enabled bits change.
            end
            aw_addr_q.push_back(aw_addr);
            aw_count++;
         end
         if (ar_hs) begin
            exp_q.push_back(model[ar_addr]);
            ar_edge_q.push_back(edge_n);
         end
      end
   end

   // ==============================
   // Stimulus
   // ==============================

   // Drives both channels on falling edges until every item has completed
   // or responses stop arriving.
   task automatic run_traffic(input int n_rd, input int n_wr, input int valid_pct,
                              input int r_pct, input int b_pct,
                              input bit seq, input bit full_mask);
      int                              rd_left;
      int                              wr_left;
      int                              r_span;
      int                              b_span;
      int                              drain;
      logic [ram_geom_pkg::ADDR_W-1:0] a;
      rd_left = n_rd;
      wr_left = n_wr;
      r_span  = 0;
      b_span  = 0;
      drain   = 0;
      while ((rd_left > 0 || wr_left > 0 || ar_valid || aw_valid ||
              exp_q.size() > 0 || aw_count != b_count) && drain < DRAIN_LIMIT) begin
         @(negedge rclk);
         if (ar_hs) ar_valid = 1'b0;
         if (aw_hs) aw_valid = 1'b0;
         if (rd_left == 0 && wr_left == 0 && !ar_valid && !aw_valid) drain++;
         if (r_span == 0) begin
            r_ready = ($urandom % 100) < r_pct;
            r_span  = 1 + $urandom % 6;       // Ready held for a random span.
         end
         r_span--;
         if (b_span == 0) begin
            b_ready = ($urandom % 100) < b_pct;
            b_span  = 1 + $urandom % 6;
         end
         b_span--;
         if (!ar_valid && rd_left > 0 && ($urandom % 100) < valid_pct) begin
            a = seq ? (n_rd - rd_left) % ram_geom_pkg::DEPTH : $urandom % ram_geom_pkg::DEPTH;
            if (wr_pend[a] == 0) begin        // Skip words with a write in flight.
               ar_valid = 1'b1;
               ar_addr  = a;
               rd_left--;
            end
         end
         if (!aw_valid && wr_left > 0 && ($urandom % 100) < valid_pct) begin
            a = seq ? (n_wr - wr_left) % ram_geom_pkg::DEPTH : $urandom % ram_geom_pkg::DEPTH;
            if (!(ar_valid && ar_addr == a)) begin
               aw_valid = 1'b1;
               aw_addr  = a;
               aw_data  = $urandom;
               aw_bwe   = full_mask ? '1 : $urandom;
               wr_pend[a]++;
               wr_left--;
            end
         end
      end
   endtask

   initial begin : stimulus
      seed       = $urandom(32'h511133f9);
      rst_rclk_n = 1'b0;
      ar_valid   = 1'b0;
      ar_addr    = '0;
      r_ready    = 1'b0;
      aw_valid   = 1'b0;
      aw_addr    = '0;
      aw_data    = '0;
      aw_bwe     = '0;
      b_ready    = 1'b0;
      foreach (wr_pend[i]) wr_pend[i] = 0;
      repeat (2) @(negedge rclk);
      rst_rclk_n = 1'b1;
      @(negedge rclk);
      run_traffic(0, 64, 100, 100, 100, 1'b1, 1'b1);   // Fill every word.
      run_traffic(0, 64, 100, 100, 100, 1'b1, 1'b0);   // Masked writes.
      run_traffic(64, 0, 100, 100, 100, 1'b1, 1'b1);   // Streaming reads.
      run_traffic(64, 0, 100, 40, 100, 1'b0, 1'b1);    // r_ready back-pressure.
      run_traffic(0, 64, 100, 100, 40, 1'b0, 1'b0);    // b_ready back-pressure.
      run_traffic(250, 250, 60, 70, 70, 1'b0, 1'b0);   // Mixed random traffic.
      repeat (2) @(negedge rclk);
      assert (aw_count == b_count)
         else report_protocol_error("The b transfer count differs from the aw count.");
      assert (exp_q.size() == 0)
         else report_protocol_error("Some reads never returned data.");
      close_run(1'b0);
   end

   initial begin : watchdog
      while (cycles < MAX_CYCLES) begin
         @(posedge rclk);
         cycles++;
      end
      $display("Timeout: the run did not finish within %0d cycles.", MAX_CYCLES);
      close_run(1'b1);
   end

endmodule : tb_srfram_channelized

// ==== rtl/srfram_channelized.sv ====
/*
 * Channelized register-file RAM, top level.
 *   srfram_channelized
 *     ar/r read channel and aw/b write channel
 *     single clock rclk, async reset rst_rclk_n
 */

`timescale 1ns/1ps

module srfram_channelized (
   input  logic                              rclk,
   input  logic                              rst_rclk_n,

   input  logic                              ar_valid,
   output logic                              ar_ready,
   input  logic [ram_geom_pkg::ADDR_W-1:0]   ar_addr,

   output logic                              r_valid,
   input  logic                              r_ready,
   output logic [ram_geom_pkg::WIDTH-1:0]    r_data,

   input  logic                              aw_valid,
   output logic                              aw_ready,
   input  logic [ram_geom_pkg::ADDR_W-1:0]   aw_addr,
   input  logic [ram_geom_pkg::WIDTH-1:0]    aw_data,
   input  logic [ram_geom_pkg::WIDTH-1:0]    aw_bwe,

   output logic                              b_valid,
   input  logic                              b_ready
);

   // ==============================
   // Core read port
   // ==============================

   logic                             reb;
   logic [ram_geom_pkg::ADDR_W-1:0]  ra;
   logic [ram_geom_pkg::WIDTH-1:0]   dout;

   ram_wr_if wr_bus ();

   rd_channel rd_channel_i (
      .rclk       (rclk),
      .rst_rclk_n (rst_rclk_n),
      .ar_valid   (ar_valid),
      .ar_ready   (ar_ready),
      .ar_addr    (ar_addr),
      .r_valid    (r_valid),
      .r_ready    (r_ready),
      .r_data     (r_data),
      .reb        (reb),
      .ra         (ra),
      .dout       (dout)
   );

   wr_channel wr_channel_i (
      .rclk       (rclk),
      .rst_rclk_n (rst_rclk_n),
      .aw_valid   (aw_valid),
      .aw_ready   (aw_ready),
      .aw_addr    (aw_addr),
      .aw_data    (aw_data),
      .aw_bwe     (aw_bwe),
      .b_valid    (b_valid),
      .b_ready    (b_ready),
      .wr         (wr_bus.chan)
   );

   srfram_core srfram_core_i (
      .rclk       (rclk),
      .reb        (reb),
      .ra         (ra),
      .dout       (dout),
      .wr         (wr_bus.core)
   );

endmodule : srfram_channelized

// ==== rtl/wr_channel.sv ====
/*
 * Write channel pipeline.
 *   wr_channel
 *     captures aw address, data and mask in the capture stage
 *     strobes the core write on promotion to the response stage
 *     response stage drives b, two writes in flight
 */

`timescale 1ns/1ps

module wr_channel (
   input  logic                              rclk,
   input  logic                              rst_rclk_n,
   input  logic                              aw_valid,
   output logic                              aw_ready,
   input  logic [ram_geom_pkg::ADDR_W-1:0]   aw_addr,
   input  logic [ram_geom_pkg::WIDTH-1:0]    aw_data,
   input  logic [ram_geom_pkg::WIDTH-1:0]    aw_bwe,
   output logic                              b_valid,
   input  logic                              b_ready,
   ram_wr_if.chan                            wr
);

   chan_pkg::slot_e                  state;
   chan_pkg::slot_e                  state_nxt;
   logic                             s0;     // Write parked in capture stage.
   logic                             s1;     // Response pending.
   logic                             n0;
   logic                             n1;
   logic                             web;
   logic [ram_geom_pkg::ADDR_W-1:0]  addr_q;
   logic [ram_geom_pkg::ADDR_W-1:0]  addr_nxt;
   logic [ram_geom_pkg::WIDTH-1:0]   data_q;
   logic [ram_geom_pkg::WIDTH-1:0]   data_nxt;
   logic [ram_geom_pkg::WIDTH-1:0]   bwe_q;
   logic [ram_geom_pkg::WIDTH-1:0]   bwe_nxt;

   assign s0      = state[0];
   assign s1      = state[1];
   assign b_valid = s1;                      // Straight from the state flop.

   // Core write port always shows the capture stage.
   assign wr.web  = web;
   assign wr.wa   = addr_q;
   assign wr.din  = data_q;
   assign wr.bwe  = bwe_q;

   // ==============================
   // Slot control
   // ==============================

   always_comb begin
      n0       = s0;
      n1       = s1;
      addr_nxt = addr_q;
      data_nxt = data_q;
      bwe_nxt  = bwe_q;
      web      = 1'b1;
      aw_ready = 1'b0;

      if (s1 && b_ready) begin
         n1 = 1'b0;                          // Response taken.
      end

      // Write lands in the array on the same edge b_valid rises.
      if (s0 && !n1) begin
         n0  = 1'b0;
         n1  = 1'b1;
         web = 1'b0;
      end

      if (aw_valid && !n0) begin
         aw_ready = 1'b1;
         n0       = 1'b1;
         addr_nxt = aw_addr;
         data_nxt = aw_data;
         bwe_nxt  = aw_bwe;
      end
   end

   always_comb begin
      unique case ({n1, n0})
         2'b00:   state_nxt = chan_pkg::SLOT_EMPTY;
         2'b01:   state_nxt = chan_pkg::SLOT_STAGE0;
         2'b10:   state_nxt = chan_pkg::SLOT_STAGE1;
         default: state_nxt = chan_pkg::SLOT_BOTH;
      endcase
   end

   // ==============================
   // Registers
   // ==============================

   always_ff @(posedge rclk or negedge rst_rclk_n) begin
      if (!rst_rclk_n) begin
         state <= chan_pkg::SLOT_EMPTY;
      end else begin
         state <= state_nxt;
      end
   end

   always_ff @(posedge rclk) begin
      addr_q <= addr_nxt;
      data_q <= data_nxt;
      bwe_q  <= bwe_nxt;
   end

endmodule : wr_channel

// ==== rtl/rd_channel.sv ====
/*
 * Read channel pipeline.
 *   rd_channel
 *     accepts ar requests and strobes the core read
 *     capture stage waits on dout, output stage drives r
 *     two reads in flight, back-pressure passed to ar_ready
 */

`timescale 1ns/1ps

module rd_channel (
   input  logic                              rclk,
   input  logic                              rst_rclk_n,
   input  logic                              ar_valid,
   output logic                              ar_ready,
   input  logic [ram_geom_pkg::ADDR_W-1:0]   ar_addr,
   output logic                              r_valid,
   input  logic                              r_ready,
   output logic [ram_geom_pkg::WIDTH-1:0]    r_data,
   output logic                              reb,
   output logic [ram_geom_pkg::ADDR_W-1:0]   ra,
   input  logic [ram_geom_pkg::WIDTH-1:0]    dout
);

   chan_pkg::slot_e                  state;
   chan_pkg::slot_e                  state_nxt;
   logic                             s0;     // Capture stage busy.
   logic                             s1;     // Output stage busy.
   logic                             n0;
   logic                             n1;
   logic [ram_geom_pkg::WIDTH-1:0]   data_q;
   logic [ram_geom_pkg::WIDTH-1:0]   data_nxt;

   assign s0      = state[0];
   assign s1      = state[1];
   assign r_valid = s1;                      // Straight from the state flop.
   assign r_data  = data_q;
   assign ra      = ar_addr;                 // Address goes to the core as is.

   // ==============================
   // Slot control
   // ==============================

   always_comb begin
      n0       = s0;
      n1       = s1;
      data_nxt = data_q;
      reb      = 1'b1;
      ar_ready = 1'b0;

      if (s1 && r_ready) begin
         n1 = 1'b0;                          // Output stage drained.
      end

      if (s0 && !n1) begin
         n0       = 1'b0;
         n1       = 1'b1;
         data_nxt = dout;                    // Promote with core data.
      end

      if (ar_valid && !n0) begin
         reb      = 1'b0;
         ar_ready = 1'b1;
         n0       = 1'b1;
      end
   end

   always_comb begin
      unique case ({n1, n0})
         2'b00:   state_nxt = chan_pkg::SLOT_EMPTY;
         2'b01:   state_nxt = chan_pkg::SLOT_STAGE0;
         2'b10:   state_nxt = chan_pkg::SLOT_STAGE1;
         default: state_nxt = chan_pkg::SLOT_BOTH;
      endcase
   end

   // ==============================
   // Registers
   // ==============================

   always_ff @(posedge rclk or negedge rst_rclk_n) begin
      if (!rst_rclk_n) begin
         state <= chan_pkg::SLOT_EMPTY;
      end else begin
         state <= state_nxt;
      end
   end

   always_ff @(posedge rclk) begin
      data_q <= data_nxt;
   end

endmodule : rd_channel

// ==== rtl/srfram_core.sv ====
/*
 * RAM core with one read and one write port.
 *   srfram_core
 *     registered synchronous read, strobed by reb
 *     bit-masked write through ram_wr_if
 *     same-address collision returns the old word
 */

`timescale 1ns/1ps

module srfram_core (
   input  logic                              rclk,
   input  logic                              reb,
   input  logic [ram_geom_pkg::ADDR_W-1:0]   ra,
   output logic [ram_geom_pkg::WIDTH-1:0]    dout,
   ram_wr_if.core                            wr
);

   // ==============================
   // Storage
   // ==============================

   logic [ram_geom_pkg::WIDTH-1:0] mem [ram_geom_pkg::DEPTH];

   logic [ram_geom_pkg::WIDTH-1:0] wr_word;  // Merged word for the write.

   // Keep unselected bits of the addressed word.
   always_comb begin
      wr_word = (mem[wr.wa] & ~wr.bwe) | (wr.din & wr.bwe);
   end

   // ==============================
   // Write port
   // ==============================

   always_ff @(posedge rclk) begin
      if (!wr.web) begin
         mem[wr.wa] <= wr_word;
      end
   end

   // ==============================
   // Read port
   // ==============================

   // Nonblocking update samples the array before this edge's write lands,
   // so a read and write to one address see the old contents.
   always_ff @(posedge rclk) begin
      if (!reb) begin
         dout <= mem[ra];                    // Holds while reb is high.
      end
   end

endmodule : srfram_core

// ==== rtl/ram_wr_if.sv ====
/*
 * Write port bundle of the RAM core.
 *   web, wa, din, bwe
 *   modport chan drives the port, modport core receives it
 */

`timescale 1ns/1ps

interface ram_wr_if;

   logic                              web;  // Write strobe, active low.
   logic [ram_geom_pkg::ADDR_W-1:0]   wa;   // Write address.
   logic [ram_geom_pkg::WIDTH-1:0]    din;  // Write data.
   logic [ram_geom_pkg::WIDTH-1:0]    bwe;  // Per-bit write enable.

   modport chan (
      output web,
      output wa,
      output din,
      output bwe
   );

   modport core (
      input web,
      input wa,
      input din,
      input bwe
   );

endinterface : ram_wr_if

// ==== rtl/chan_pkg.sv ====
/*
 * Channel pipeline package.
 *   slot_e  occupancy of a two-slot valid/ready pipeline
 */

package chan_pkg;

   // Bit 0 marks the capture stage, bit 1 the output stage.
   typedef enum logic [1:0] {
      SLOT_EMPTY  = 2'b00,                   // Nothing in flight.
      SLOT_STAGE0 = 2'b01,                   // Item in capture stage.
      SLOT_STAGE1 = 2'b10,                   // Item in output stage.
      SLOT_BOTH   = 2'b11                    // Both stages occupied.
   } slot_e;

endpackage : chan_pkg

// ==== rtl/ram_geom_pkg.sv ====
/*
 * RAM geometry package.
 *   WIDTH   bits per word
 *   DEPTH   number of words
 *   ADDR_W  address width derived from DEPTH
 */

package ram_geom_pkg;

   // ==============================
   // Array dimensions
   // ==============================

   localparam int WIDTH  = 32;               // Bits per word.
   localparam int DEPTH  = 64;               // Words in the array.

   // ==============================
   // Derived widths
   // ==============================

   localparam int ADDR_W = $clog2(DEPTH);    // Address bits, 6 for 64 words.

endpackage : ram_geom_pkg
